// File: source/rv_core_pkg.sv
// rv32i core slice shared definitions
// word and index types, instruction kinds, opcodes and adder operand selects
package rv_core_pkg;

    // one data word, also used for immediates and the pc
    typedef logic [31:0] xlen_t;
    // raw instruction word
    typedef logic [31:0] inst_t;
    // register file index
    typedef logic [4:0]  reg_idx_t;

    // instruction format kind
    // encodings match the controller key
    typedef enum logic [2:0] {
        kind_i     = 3'b000,
        kind_b     = 3'b001,
        kind_u     = 3'b010,
        kind_r     = 3'b011,
        kind_s     = 3'b100,
        kind_jalr  = 3'b101,
        kind_j     = 3'b110,
        kind_other = 3'b111
    } inst_kind_t;

    // adder operand a source
    typedef enum logic [1:0] {
        src_a_reg,
        src_a_pc,
        src_a_zero
    } src_a_sel_t;

    // adder operand b source
    typedef enum logic [1:0] {
        src_b_reg,
        src_b_imm,
        src_b_four
    } src_b_sel_t;

    // major opcodes kept by this slice
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    // funct3 of add, addi and jalr
    localparam logic [2:0] f3_zero   = 3'b000;

endpackage

// File: source/rv_decoder.sv
// instruction decoder for the rv32i slice
// sorts the word into a kind, builds the immediate and drives the datapath controls
`timescale 1ns/1ps

module rv_decoder
    import rv_core_pkg::*;
(
    input  inst_t      instr,
    output inst_kind_t kind,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output xlen_t      imm,
    output src_a_sel_t src_a_sel,
    output src_b_sel_t src_b_sel,
    output logic       reg_write,
    output logic       pc_jump,
    output logic       pc_from_reg
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_j;

    // fixed rv32i field positions
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // kind lookup
    // only add, addi and jalr of their opcode groups are kept
    always_comb begin
        kind = kind_other;
        case (opcode)
            op_op_imm: begin
                if (funct3 == f3_zero) begin
                    kind = kind_i;
                end
            end
            op_op: begin
                // sub and the logic ops fall through to other
                if (funct3 == f3_zero && funct7 == 7'b0000000) begin
                    kind = kind_r;
                end
            end
            op_lui, op_auipc: begin
                kind = kind_u;
            end
            op_jal: begin
                kind = kind_j;
            end
            op_jalr: begin
                if (funct3 == f3_zero) begin
                    kind = kind_jalr;
                end
            end
            default: begin
                kind = kind_other;
            end
        endcase
    end

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    // j-type bits are scattered, bit 0 always zero
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (kind)
            kind_u:  imm = imm_u;
            kind_j:  imm = imm_j;
            default: imm = imm_i;
        endcase
    end

    // operand a
    // auipc and both jumps add to the pc, lui adds to zero
    always_comb begin
        if (opcode == op_auipc || kind == kind_j || kind == kind_jalr) begin
            src_a_sel = src_a_pc;
        end else if (opcode == op_lui) begin
            src_a_sel = src_a_zero;
        end else begin
            src_a_sel = src_a_reg;
        end
    end

    // operand b
    // jumps form the link value pc plus four
    always_comb begin
        if (kind == kind_j || kind == kind_jalr) begin
            src_b_sel = src_b_four;
        end else if (kind == kind_r) begin
            src_b_sel = src_b_reg;
        end else begin
            src_b_sel = src_b_imm;
        end
    end

    // writes for i/r/u/j kinds, never to x0
    assign reg_write = (kind == kind_i || kind == kind_r || kind == kind_u ||
                        kind == kind_jalr || kind == kind_j) && (rd != 5'd0);

    // jal and jalr redirect the pc, jalr from rs1
    assign pc_jump     = (kind == kind_j) || (kind == kind_jalr);
    assign pc_from_reg = (kind == kind_jalr);

endmodule

// File: source/rv_regfile.sv
// integer register file, x0 tied to zero
// two combinational read ports and one write port on the rising edge
`timescale 1ns/1ps

module rv_regfile
    import rv_core_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arst_n,
    input  reg_idx_t        rs1,
    input  reg_idx_t        rs2,
    input  reg_idx_t        rd,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data
);

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    // all writable registers start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // reads see the old value on a same-cycle write
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

// File: source/rv_execute.sv
// execute stage of the rv32i slice
// two operand muxes feeding the single adder
`timescale 1ns/1ps

module rv_execute
    import rv_core_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  src_a_sel_t      src_a_sel,
    input  src_b_sel_t      src_b_sel,
    output logic [XLEN-1:0] sum
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    // operand a
    // rs1 for addi/add, pc for auipc/jal/jalr, zero for lui
    always_comb begin
        case (src_a_sel)
            src_a_reg:  op_a = rs1_data;
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = '0;
            default:    op_a = '0;
        endcase
    end

    // operand b
    // rs2 for add, four for the link value, immediate otherwise
    always_comb begin
        case (src_b_sel)
            src_b_reg:  op_b = rs2_data;
            src_b_imm:  op_b = imm;
            src_b_four: op_b = XLEN'(4);
            default:    op_b = imm;
        endcase
    end

    // the only alu operation
    assign sum = op_a + op_b;

endmodule

// File: source/rv_writeback.sv
// writeback and pc update for the rv32i slice
// holds the pc register, picks the next pc and passes the adder sum to rd
`timescale 1ns/1ps

module rv_writeback #(
    parameter int              XLEN     = 32,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [XLEN-1:0] sum,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] rs1_data,
    input  logic            pc_jump,
    input  logic            pc_from_reg,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] wdata
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_seq;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] jump_target;

    // sequential fetch
    assign pc_seq = pc_q + XLEN'(4);

    // jal jumps off the pc, jalr off rs1
    assign jump_base   = pc_from_reg ? rs1_data : pc_q;
    assign jump_target = jump_base + imm;

    // jalr clears bit 0 of its target, jal target is already even
    always_comb begin
        if (!pc_jump) begin
            pc_next = pc_seq;
        end else if (pc_from_reg) begin
            pc_next = {jump_target[XLEN-1:1], 1'b0};
        end else begin
            pc_next = jump_target;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc = pc_q;

    // adder result also covers the jal/jalr link value
    assign wdata = sum;

endmodule

// File: source/rv_core_top.sv
// single-cycle rv32i core slice
// decode, register file, execute and writeback, one instruction retired per cycle
`timescale 1ns/1ps

module rv_core_top
    import rv_core_pkg::*;
#(
    parameter int              XLEN     = 32,
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  inst_t           instr,
    output logic [XLEN-1:0] pc,
    output logic            retire,
    output logic            rd_we,
    output reg_idx_t        rd_addr,
    output logic [XLEN-1:0] rd_wdata
);

    reg_idx_t        rs1;
    reg_idx_t        rs2;
    reg_idx_t        rd;
    xlen_t           imm;
    src_a_sel_t      src_a_sel;
    src_b_sel_t      src_b_sel;
    logic            reg_write;
    logic            pc_jump;
    logic            pc_from_reg;
    logic [XLEN-1:0] imm_x;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] wdata;
    logic            retire_q;
    logic            wb_jump;
    logic            wb_from_reg;
    logic [XLEN-1:0] wb_imm;

    rv_decoder u_rv_decoder (
        .instr       (instr),
        .kind        (),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .reg_write   (reg_write),
        .pc_jump     (pc_jump),
        .pc_from_reg (pc_from_reg)
    );

    // immediates are signed, so a wider core just sign-extends them
    assign imm_x = XLEN'($signed(imm));

    rv_regfile #(.XLEN(XLEN)) u_rv_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (rd_we),
        .wdata    (wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute #(.XLEN(XLEN)) u_rv_execute (
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm_x),
        .src_a_sel (src_a_sel),
        .src_b_sel (src_b_sel),
        .sum       (sum)
    );

    // before the first retirement the pc jumps to itself plus zero
    // so the instruction at RESET_PC is the first one retired
    assign wb_jump     = pc_jump | ~retire_q;
    assign wb_from_reg = pc_from_reg & retire_q;
    assign wb_imm      = retire_q ? imm_x : '0;

    rv_writeback #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_rv_writeback (
        .clk         (clk),
        .arst_n      (arst_n),
        .sum         (sum),
        .imm         (wb_imm),
        .rs1_data    (rs1_data),
        .pc_jump     (wb_jump),
        .pc_from_reg (wb_from_reg),
        .pc          (pc),
        .wdata       (wdata)
    );

    // low through reset, high from the first edge after it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_q <= 1'b0;
        end else begin
            retire_q <= 1'b1;
        end
    end

    assign retire   = retire_q;
    // no register write until the core retires
    assign rd_we    = reg_write & retire_q;
    assign rd_addr  = rd;
    assign rd_wdata = wdata;

endmodule

// File: dv/rv_core_sva.sv
// bound checks on the rv32i core slice
// pc alignment, x0 writes and retire during reset
`timescale 1ns/1ps

module rv_core_sva
    import rv_core_pkg::*;
#(
    parameter int XLEN = 32
) (
    input logic            clk,
    input logic            arst_n,
    input logic [XLEN-1:0] pc,
    input logic            retire,
    input logic            rd_we,
    input reg_idx_t        rd_addr
);

    // failures so far, picked up by the testbench summary
    int fail_count = 0;

    // x0 is never a write target
    no_x0_write: assert property (
        @(posedge clk) disable iff (!arst_n) !(rd_we && rd_addr == 5'd0)
    ) else begin
        fail_count++;
        $error("rd_we high with rd_addr zero");
    end

    // only word aligned fetch addresses
    pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("pc not word aligned: %h", pc);
    end

    // no retirement while reset is held
    no_retire_in_reset: assert property (
        @(posedge clk) !arst_n |-> !retire
    ) else begin
        fail_count++;
        $error("retire high during reset");
    end

endmodule

bind rv_core_top rv_core_sva #(.XLEN(XLEN)) u_rv_core_sva (
    .clk     (clk),
    .arst_n  (arst_n),
    .pc      (pc),
    .retire  (retire),
    .rd_we   (rd_we),
    .rd_addr (rd_addr)
);

// File: dv/tb_rv_core.sv
// testbench for the single-cycle rv32i core slice
// runs a fixed program and checks every retirement against a reference model
`timescale 1ns/1ps

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int    XLEN       = 32;
    localparam xlen_t RESET_PC   = 32'h0000_0000;
    localparam int    N_ROWS     = 25;
    localparam int    CLK_PERIOD = 8;

    // opcodes as listed in the isa manual
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_store  = 7'b0100011;
    // addi x0, x0, 0
    localparam inst_t nop_word = 32'h0000_0013;

    // one program row, expected values filled by the reference model
    typedef struct packed {
        inst_t    instr;
        logic     we;
        reg_idx_t rd;
        xlen_t    wdata;
        xlen_t    next_pc;
    } row_t;

    logic     clk;
    logic     arst_n;
    inst_t    instr;
    xlen_t    pc;
    logic     retire;
    logic     rd_we;
    reg_idx_t rd_addr;
    xlen_t    rd_wdata;

    row_t   prog [N_ROWS];
    xlen_t  model_regs [32];
    integer seed;
    int     n_steps;
    int     check_count;
    int     error_count;

    rv_core_top #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_rv_core_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .instr    (instr),
        .pc       (pc),
        .retire   (retire),
        .rd_we    (rd_we),
        .rd_addr  (rd_addr),
        .rd_wdata (rd_wdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // instruction encoders
    function automatic inst_t enc_i(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm,
                                    logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic inst_t enc_r(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [6:0] f7, logic [6:0] opc);
        return {f7, rs2, rs1, 3'b000, rd, opc};
    endfunction

    function automatic inst_t enc_u(reg_idx_t rd, logic [19:0] imm, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // byte offset, bit 0 dropped by the format
    function automatic inst_t enc_j(reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    function automatic logic in_table(xlen_t addr);
        return ((addr - RESET_PC) < xlen_t'(N_ROWS * 4)) && (addr[1:0] == 2'b00);
    endfunction

    function automatic int row_of(xlen_t addr);
        return int'((addr - RESET_PC) >> 2);
    endfunction

    // instruction memory seen by the core, nop outside the program
    function automatic inst_t fetch_word(xlen_t addr);
        if (in_table(addr)) begin
            return prog[row_of(addr)].instr;
        end
        return nop_word;
    endfunction

    // reference model of one retirement
    task automatic model_step(input inst_t word, input xlen_t cur_pc, output logic we,
                              output reg_idx_t rd, output xlen_t wdata,
                              output xlen_t next_pc);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      imm_i;
        xlen_t      imm_u;
        xlen_t      imm_j;
        logic       writes;
        opc     = word[6:0];
        f3      = word[14:12];
        f7      = word[31:25];
        rs1     = word[19:15];
        rs2     = word[24:20];
        rd      = word[11:7];
        imm_i   = {{20{word[31]}}, word[31:20]};
        imm_u   = {word[31:12], 12'h000};
        imm_j   = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        writes  = 1'b1;
        wdata   = '0;
        next_pc = cur_pc + 32'd4;
        if (opc == opc_op_imm && f3 == 3'b000) begin
            wdata = model_regs[rs1] + imm_i;
        end else if (opc == opc_op && f3 == 3'b000 && f7 == 7'h00) begin
            wdata = model_regs[rs1] + model_regs[rs2];
        end else if (opc == opc_lui) begin
            wdata = imm_u;
        end else if (opc == opc_auipc) begin
            wdata = cur_pc + imm_u;
        end else if (opc == opc_jal) begin
            wdata   = cur_pc + 32'd4;
            next_pc = cur_pc + imm_j;
        end else if (opc == opc_jalr && f3 == 3'b000) begin
            // target uses rs1 before the link write
            wdata   = cur_pc + 32'd4;
            next_pc = (model_regs[rs1] + imm_i) & ~32'd1;
        end else begin
            writes = 1'b0;
        end
        we = writes && (rd != 5'd0);
        if (we) begin
            model_regs[rd] = wdata;
        end
    endtask

    // program rows in address order, jumps only go forward
    task automatic build_program();
        xlen_t    rnd;
        xlen_t    cur;
        int       row;
        logic     we;
        reg_idx_t rd;
        xlen_t    wdata;
        xlen_t    next_pc;
        // addi/add chain, negative immediates forced by bit 11
        rnd = $random(seed);
        prog[0].instr = enc_i(5'd1, 5'd0, rnd[11:0], opc_op_imm);
        rnd = $random(seed);
        prog[1].instr = enc_i(5'd2, 5'd1, {1'b1, rnd[10:0]}, opc_op_imm);
        prog[2].instr = enc_r(5'd3, 5'd1, 5'd2, 7'h00, opc_op);
        rnd = $random(seed);
        prog[3].instr = enc_i(5'd4, 5'd3, {1'b1, rnd[10:0]}, opc_op_imm);
        rnd = $random(seed);
        prog[4].instr = enc_u(5'd5, rnd[19:0], opc_lui);
        rnd = $random(seed);
        prog[5].instr = enc_u(5'd6, rnd[31:12], opc_lui);
        prog[6].instr = enc_r(5'd7, 5'd5, 5'd4, 7'h00, opc_op);
        prog[7].instr = enc_u(5'd8, 20'h12345, opc_auipc);
        // no write: x0 target, a store, a sub
        prog[8].instr  = enc_i(5'd0, 5'd1, 12'h007, opc_op_imm);
        prog[9].instr  = enc_r(5'd0, 5'd1, 5'd2, 7'h00, opc_store);
        prog[10].instr = enc_r(5'd9, 5'd1, 5'd2, 7'h20, opc_op);
        // jal over rows 12 and 13
        prog[11].instr = enc_j(5'd10, 21'd12);
        prog[12].instr = enc_i(5'd11, 5'd0, 12'h001, opc_op_imm);
        prog[13].instr = enc_i(5'd11, 5'd0, 12'h002, opc_op_imm);
        // jalr with an odd sum lands on row 18
        prog[14].instr = enc_u(5'd12, 20'h00000, opc_auipc);
        prog[15].instr = enc_i(5'd13, 5'd12, 12'd17, opc_jalr);
        prog[16].instr = enc_i(5'd11, 5'd0, 12'h003, opc_op_imm);
        prog[17].instr = enc_i(5'd11, 5'd0, 12'h004, opc_op_imm);
        prog[18].instr = enc_r(5'd14, 5'd13, 5'd10, 7'h00, opc_op);
        // jal to x0 jumps without a write
        prog[19].instr = enc_j(5'd0, 21'd8);
        prog[20].instr = enc_i(5'd11, 5'd0, 12'h005, opc_op_imm);
        rnd = $random(seed);
        prog[21].instr = enc_i(5'd15, 5'd7, rnd[11:0], opc_op_imm);
        rnd = $random(seed);
        prog[22].instr = enc_u(5'd16, rnd[19:0], opc_lui);
        prog[23].instr = enc_r(5'd17, 5'd16, 5'd15, 7'h00, opc_op);
        rnd = $random(seed);
        prog[24].instr = enc_i(5'd18, 5'd13, {1'b1, rnd[10:0]}, opc_op_imm);

        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            prog[i].we      = 1'b0;
            prog[i].rd      = '0;
            prog[i].wdata   = '0;
            prog[i].next_pc = '0;
        end
        // walk the program in execution order
        cur     = RESET_PC;
        n_steps = 0;
        while (in_table(cur) && n_steps < N_ROWS) begin
            row = row_of(cur);
            model_step(prog[row].instr, cur, we, rd, wdata, next_pc);
            prog[row].we      = we;
            prog[row].rd      = rd;
            prog[row].wdata   = wdata;
            prog[row].next_pc = next_pc;
            cur = next_pc;
            n_steps++;
        end
    endtask

    task automatic check_pc(input xlen_t got, input xlen_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR pc got %h expected %h", got, exp);
        end
    endtask

    task automatic check_we(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg_write(input reg_idx_t got_rd, input reg_idx_t exp_rd,
                                   input xlen_t got_data, input xlen_t exp_data);
        check_count++;
        if (got_rd !== exp_rd) begin
            error_count++;
            $display("ERROR rd_addr got %h expected %h", got_rd, exp_rd);
        end
        check_count++;
        if (got_data !== exp_data) begin
            error_count++;
            $display("ERROR rd_wdata got %h expected %h", got_data, exp_data);
        end
    endtask

    initial begin
        int    row;
        int    errs_before;
        xlen_t cur_pc;
        arst_n      = 1'b0;
        instr       = nop_word;
        seed        = 32'h2028_0653;
        check_count = 0;
        error_count = 0;
        build_program();

        // reset for 4 cycles, state checked inside it
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_we("retire", retire, 1'b0);
        check_we("rd_we", rd_we, 1'b0);
        check_pc(pc, RESET_PC);
        @(posedge clk);
        arst_n <= 1'b1;
        instr  <= fetch_word(RESET_PC);

        // first cycle out of reset retires nothing
        @(negedge clk);
        check_we("retire", retire, 1'b0);
        check_we("rd_we", rd_we, 1'b0);
        check_pc(pc, RESET_PC);
        $display("reset released, pc %h, retire low", pc);
        @(posedge clk);

        cur_pc = RESET_PC;
        for (int step = 0; step < n_steps; step++) begin
            @(negedge clk);
            row         = row_of(cur_pc);
            errs_before = error_count;
            check_pc(pc, cur_pc);
            check_we("retire", retire, 1'b1);
            check_we("rd_we", rd_we, prog[row].we);
            if (prog[row].we) begin
                check_reg_write(rd_addr, prog[row].rd, rd_wdata, prog[row].wdata);
            end
            $display("row %0d pc %h instr %h done, %0d errors", row, cur_pc,
                     prog[row].instr, error_count - errs_before);
            cur_pc = prog[row].next_pc;
            // next fetch goes to the address the pc moves to on this edge
            @(posedge clk);
            instr <= fetch_word(cur_pc);
        end
        @(negedge clk);
        check_pc(pc, cur_pc);

        error_count += u_rv_core_top.u_rv_core_sva.fail_count;
        $display("rows retired %0d, checks %0d, errors %0d", n_steps, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog, program length plus margin
    initial begin
        #((N_ROWS + 20) * CLK_PERIOD);
        $display("timeout: the program did not finish within %0d cycles", N_ROWS + 20);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: project.f
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_writeback.sv
source/rv_core_top.sv
dv/rv_core_sva.sv
dv/tb_rv_core.sv

// File: Makefile
# Verilator build and run of the rv32i core slice testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_rv_core
FILELIST  ?= project.f

.PHONY: sim clean

# pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
